// ==== hw/ramio_pkg.sv ====
// ----------------------------
// shared definitions for the load/store port
// address map, sizes, uart bit time and request structs
// modules refer to these by scoped names
// ----------------------------
package ramio_pkg;

  // client side widths
  localparam int data_width = 32;
  localparam int addr_width = 32;

  // word ram holds 2^8 words, index taken from address bits 9..2
  localparam int ram_addr_width = 8;

  // ------------------------------
  // i/o register map
  // ------------------------------
  // 4 leds in the low nibble, 0 is on
  localparam logic [addr_width-1:0] addr_led = 32'hffff_fffc;
  // reads all ones when transmitter idle
  localparam logic [addr_width-1:0] addr_uart_out = 32'hffff_fff8;
  // reads all ones when empty, cleared on read
  localparam logic [addr_width-1:0] addr_uart_in = 32'hffff_fff4;

  // uart bit time in clocks, kept short for simulation
  localparam int uart_clocks_per_bit = 8;
  localparam int uart_cnt_width = $clog2(uart_clocks_per_bit);

  // client access as presented by the cpu
  typedef struct packed {
    logic                  enable;
    // bit 2 sign extends, 01 byte, 10 half, 11 word
    logic [2:0]            read_type;
    // 01 byte, 10 half, 11 word
    logic [1:0]            write_type;
    logic [addr_width-1:0] address;
    logic [data_width-1:0] data_in;
  } mem_req_t;

  // byte-lane access to the word ram
  typedef struct packed {
    logic                      enable;
    logic [ram_addr_width-1:0] word_addr;
    // bit 0 is the lowest byte
    logic [data_width/8-1:0]   byte_en;
    logic [data_width-1:0]     wdata;
  } ram_req_t;

endpackage

// ==== hw/ramio.sv ====
// ----------------------------
// control for the load/store port
// decodes the i/o map, owns led and uart registers
// and steers ram requests, busy and ready
// ----------------------------
`timescale 1ns/1ns

module ramio (
  input  logic                                clk,
  input  logic                                rst_n,
  input  ramio_pkg::mem_req_t                 req,
  input  logic [ramio_pkg::data_width-1:0]    ram_rdata_ext,
  input  logic [ramio_pkg::data_width/8-1:0]  lane_byte_en,
  input  logic [ramio_pkg::data_width-1:0]    lane_wdata,
  input  logic                                ram_ready,
  input  logic                                tx_busy,
  input  logic [7:0]                          rx_data,
  input  logic                                rx_data_ready,
  output ramio_pkg::ram_req_t                 ram_req,
  output logic [ramio_pkg::data_width-1:0]    data_out,
  output logic                                data_out_ready,
  output logic                                busy,
  output logic [3:0]                          led,
  output logic [7:0]                          tx_data,
  output logic                                tx_go,
  output logic                                rx_go
);

  // address decode
  logic is_led;
  logic is_tx;
  logic is_rx;
  logic is_io;
  // qualified access kinds
  logic is_write;
  logic is_read;

  // byte being sent, all ones when idle
  logic [ramio_pkg::data_width-1:0] tx_reg;
  // last byte received, all ones when empty
  logic [ramio_pkg::data_width-1:0] rx_reg;

  assign is_led = req.address == ramio_pkg::addr_led;
  assign is_tx  = req.address == ramio_pkg::addr_uart_out;
  assign is_rx  = req.address == ramio_pkg::addr_uart_in;
  assign is_io  = is_led | is_tx | is_rx;

  assign is_write = req.enable && (req.write_type != 2'b00);
  assign is_read  = req.enable && (req.read_type != 3'b000);

  // ------------------------------
  // busy / ready
  // ------------------------------
  // i/o always answers at once, even with enable low
  // ram writes finish at the next edge, reads wait one cycle for the word
  assign busy           = ~is_io & ~is_write & req.enable & ~ram_ready;
  assign data_out_ready = is_io | is_write | ram_ready;

  // ram request, lane steering comes from lane_align
  assign ram_req.enable    = req.enable & ~is_io;
  assign ram_req.word_addr = req.address[ramio_pkg::ram_addr_width+1:2];
  assign ram_req.byte_en   = (req.enable && !is_io) ? lane_byte_en : '0;
  assign ram_req.wdata     = lane_wdata;

  // read mux, led reads back as zero
  always_comb begin
    data_out = '0;
    if (is_read) begin
      if (is_tx) begin
        data_out = tx_reg;
      end else if (is_rx) begin
        data_out = rx_reg;
      end else if (!is_led) begin
        data_out = ram_rdata_ext;
      end
    end
  end

  assign tx_data = tx_reg[7:0];

  // ------------------------------
  // i/o registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // all leds off
      led    <= 4'b1111;
      tx_reg <= '1;
      tx_go  <= 1'b0;
      rx_reg <= '1;
      rx_go  <= 1'b1;
    end else begin
      // ack lasts one cycle, then receiver is armed again
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // a read empties the register and wins over a capture
      if (is_read && is_rx) begin
        rx_reg <= '1;
      end else if (rx_go && rx_data_ready) begin
        rx_reg <= {24'h0, rx_data};
        rx_go  <= 1'b0;
      end

      // frame done, drop go and show idle
      if (tx_go && !tx_busy) begin
        tx_go  <= 1'b0;
        tx_reg <= '1;
      end

      // new byte to send, overwrites whatever is pending
      if (is_write && is_tx) begin
        tx_reg <= {24'h0, req.data_in[7:0]};
        tx_go  <= 1'b1;
      end

      if (is_write && is_led) begin
        led <= req.data_in[3:0];
      end
    end
  end

endmodule

// ==== hw/lane_align.sv ====
// ----------------------------
// byte lane steering between client and word ram
// builds byte enables and placed write data,
// extends the addressed part of a read word
// ----------------------------
`timescale 1ns/1ns

module lane_align (
  input  logic [1:0]                          addr_lo,
  input  logic [2:0]                          read_type,
  input  logic [1:0]                          write_type,
  input  logic [ramio_pkg::data_width-1:0]    data_in,
  input  logic [ramio_pkg::data_width-1:0]    ram_rdata,
  output logic [ramio_pkg::data_width/8-1:0]  byte_en,
  output logic [ramio_pkg::data_width-1:0]    wdata,
  output logic [ramio_pkg::data_width-1:0]    rdata_ext
);

  // read word moved so the addressed byte sits in lane 0
  logic [ramio_pkg::data_width-1:0] rd_shift;
  logic                             sext;

  // ------------------------------
  // write side
  // ------------------------------
  always_comb begin
    byte_en = '0;
    wdata   = '0;
    unique case (write_type)
      2'b01: begin
        // byte goes to any lane
        byte_en = 4'b0001 << addr_lo;
        wdata   = ramio_pkg::data_width'(data_in[7:0]) << {addr_lo, 3'b000};
      end
      2'b10: begin
        // half word only on lane pair 0 or 2
        if (!addr_lo[0]) begin
          byte_en = addr_lo[1] ? 4'b1100 : 4'b0011;
          wdata   = ramio_pkg::data_width'(data_in[15:0]) << {addr_lo[1], 4'b0000};
        end
      end
      2'b11: begin
        if (addr_lo == 2'b00) begin
          byte_en = 4'b1111;
          wdata   = data_in;
        end
      end
      default: ;
    endcase
  end

  // ------------------------------
  // read side
  // ------------------------------
  assign rd_shift = ram_rdata >> {addr_lo, 3'b000};
  assign sext     = read_type[2];

  always_comb begin
    rdata_ext = '0;
    unique case (read_type[1:0])
      2'b01: rdata_ext = {{24{sext & rd_shift[7]}}, rd_shift[7:0]};
      2'b10: begin
        // misaligned half word reads zero
        if (!addr_lo[0]) begin
          rdata_ext = {{16{sext & rd_shift[15]}}, rd_shift[15:0]};
        end
      end
      2'b11: begin
        if (addr_lo == 2'b00) begin
          rdata_ext = ram_rdata;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/word_ram.sv ====
// ----------------------------
// byte-enabled word ram, registered read
// ready once the same word has been held a cycle
// ----------------------------
`timescale 1ns/1ns

module word_ram (
  input  logic                              clk,
  input  logic                              rst_n,
  input  ramio_pkg::ram_req_t               req,
  output logic [ramio_pkg::data_width-1:0]  rdata,
  output logic                              ready
);

  logic [ramio_pkg::data_width-1:0] mem [2**ramio_pkg::ram_addr_width];

  // word index seen last cycle and whether it was a live request
  logic [ramio_pkg::ram_addr_width-1:0] last_addr;
  logic                                 last_valid;

  // read every cycle, written bytes go straight into rdata
  always_ff @(posedge clk) begin
    for (int i = 0; i < ramio_pkg::data_width / 8; i++) begin
      if (req.enable && req.byte_en[i]) begin
        mem[req.word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
        rdata[8*i +: 8]              <= req.wdata[8*i +: 8];
      end else begin
        rdata[8*i +: 8] <= mem[req.word_addr][8*i +: 8];
      end
    end
    last_addr <= req.word_addr;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_valid <= 1'b0;
    end else begin
      last_valid <= req.enable;
    end
  end

  // address change or dropped enable clears it
  assign ready = last_valid && req.enable && (req.word_addr == last_addr);

endmodule

// ==== hw/uart_tx.sv ====
// ----------------------------
// uart transmitter, 8N1
// raise go with data, busy drops after the stop bit,
// then go must fall before the next byte
// ----------------------------
`timescale 1ns/1ns

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       tx,
  output logic       busy
);

  localparam logic [ramio_pkg::uart_cnt_width-1:0] cnt_last =
    ramio_pkg::uart_cnt_width'(ramio_pkg::uart_clocks_per_bit - 1);

  logic                                active;
  // frame sent, waiting for go to fall
  logic                                wait_low;
  // stop, data, start; shifted out lsb first
  logic [9:0]                          frame;
  logic [ramio_pkg::uart_cnt_width-1:0] cnt;
  logic [3:0]                          bit_idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active   <= 1'b0;
      wait_low <= 1'b0;
      cnt      <= '0;
      bit_idx  <= '0;
    end else if (active) begin
      if (cnt == cnt_last) begin
        cnt   <= '0;
        frame <= {1'b1, frame[9:1]};
        // last bit is the stop bit
        if (bit_idx == 4'd9) begin
          active   <= 1'b0;
          wait_low <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else if (wait_low) begin
      if (!go) begin
        wait_low <= 1'b0;
      end
    end else if (go) begin
      active  <= 1'b1;
      frame   <= {1'b1, data, 1'b0};
      cnt     <= '0;
      bit_idx <= '0;
    end
  end

  // line idles high
  assign tx   = active ? frame[0] : 1'b1;
  // high from the go cycle on, so the client never sees a false done
  assign busy = active | (go & ~wait_low);

endmodule

// ==== hw/uart_rx.sv ====
// ----------------------------
// uart receiver, 8N1
// data_ready rises after the stop bit sample
// and is cleared when go falls
// ----------------------------
`timescale 1ns/1ns

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam logic [ramio_pkg::uart_cnt_width-1:0] cnt_full =
    ramio_pkg::uart_cnt_width'(ramio_pkg::uart_clocks_per_bit - 1);
  localparam logic [ramio_pkg::uart_cnt_width-1:0] cnt_half =
    ramio_pkg::uart_cnt_width'(ramio_pkg::uart_clocks_per_bit / 2 - 1);

  // two flop synchronizer plus one for edge detect
  logic                                rx_meta;
  logic                                rx_sync;
  logic                                rx_prev;
  logic                                active;
  // counts down to the next mid-bit sample
  logic [ramio_pkg::uart_cnt_width-1:0] cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]                          bit_idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      rx_prev    <= 1'b1;
      active     <= 1'b0;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;

      // ack from the client
      if (!go) begin
        data_ready <= 1'b0;
      end

      if (!active) begin
        // falling edge starts a frame, first sample half a bit in
        if (rx_prev && !rx_sync) begin
          active  <= 1'b1;
          cnt     <= cnt_half;
          bit_idx <= '0;
        end
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end else begin
        cnt     <= cnt_full;
        bit_idx <= bit_idx + 4'd1;
        if (bit_idx == 4'd0) begin
          // glitch, start bit gone by mid-bit
          if (rx_sync) begin
            active <= 1'b0;
          end
        end else if (bit_idx == 4'd9) begin
          active     <= 1'b0;
          data_ready <= 1'b1;
        end else begin
          // lsb first
          data <= {rx_sync, data[7:1]};
        end
      end
    end
  end

endmodule

// ==== hw/ramio_top.sv ====
// ----------------------------
// top of the load/store port
// packs the client access and wires the blocks
// ----------------------------
`timescale 1ns/1ns

module ramio_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              enable,
  input  logic [2:0]                        read_type,
  input  logic [1:0]                        write_type,
  input  logic [ramio_pkg::addr_width-1:0]  address,
  input  logic [ramio_pkg::data_width-1:0]  data_in,
  input  logic                              uart_rx,
  output logic [ramio_pkg::data_width-1:0]  data_out,
  output logic                              data_out_ready,
  output logic                              busy,
  output logic [3:0]                        led,
  output logic                              uart_tx
);

  ramio_pkg::mem_req_t                req;
  ramio_pkg::ram_req_t                ram_req;
  logic [ramio_pkg::data_width-1:0]   ram_rdata;
  logic [ramio_pkg::data_width-1:0]   ram_rdata_ext;
  logic [ramio_pkg::data_width/8-1:0] lane_byte_en;
  logic [ramio_pkg::data_width-1:0]   lane_wdata;
  logic                               ram_ready;
  // uart handshake levels
  logic       tx_busy;
  logic       tx_go;
  logic [7:0] tx_data;
  logic       rx_go;
  logic [7:0] rx_data;
  logic       rx_data_ready;

  assign req = '{enable: enable, read_type: read_type, write_type: write_type,
                 address: address, data_in: data_in};

  ramio u_ramio (
    .clk, .rst_n, .req, .ram_rdata_ext, .lane_byte_en, .lane_wdata, .ram_ready,
    .tx_busy, .rx_data, .rx_data_ready, .ram_req, .data_out, .data_out_ready,
    .busy, .led, .tx_data, .tx_go, .rx_go
  );

  lane_align u_lane_align (
    .addr_lo(address[1:0]), .read_type, .write_type, .data_in,
    .ram_rdata, .byte_en(lane_byte_en), .wdata(lane_wdata), .rdata_ext(ram_rdata_ext)
  );

  word_ram u_word_ram (.clk, .rst_n, .req(ram_req), .rdata(ram_rdata), .ready(ram_ready));

  uart_tx u_uart_tx (.clk, .rst_n, .data(tx_data), .go(tx_go), .tx(uart_tx), .busy(tx_busy));

  uart_rx u_uart_rx (
    .clk, .rst_n, .rx(uart_rx), .go(rx_go), .data(rx_data), .data_ready(rx_data_ready)
  );

endmodule

// ==== tests/ramio_tb.sv ====
// ----------------------------
// testbench for the load/store port
// random ram traffic against a shadow array, led writes,
// uart round trips over a loopback, i/o ready timing
// ----------------------------
`timescale 1ns/1ns

module ramio_tb;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [2:0]  read_type;
  logic [1:0]  write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        uart_tx_line;
  logic        uart_rx_line;

  // expected ram contents
  logic [31:0] shadow [256];
  logic [31:0] rng_state;
  logic [31:0] word_addrs [40];
  // what the last access saw
  logic        first_ready;
  logic        first_busy;
  logic [31:0] last_rdata;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  int          ready_timeout = 20;
  int          uart_timeout = 300;

  // loopback line reads idle until the transmitter leaves reset
  assign uart_rx_line = (uart_tx_line === 1'b0) ? 1'b0 : 1'b1;

  ramio_top uut (
    .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
    .uart_rx(uart_rx_line), .data_out, .data_out_ready, .busy, .led,
    .uart_tx(uart_tx_line)
  );

  always #2 clk = ~clk;

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  // byte to any lane, half to lanes 0/2, word aligned only
  function automatic void ref_write(input logic [31:0] addr, input logic [1:0] wtype,
                                    input logic [31:0] wdata);
    logic [7:0] idx;
    idx = addr[9:2];
    case (wtype)
      2'b01: shadow[idx][8*addr[1:0] +: 8] = wdata[7:0];
      2'b10: begin
        if (!addr[0]) begin
          shadow[idx][16*addr[1] +: 16] = wdata[15:0];
        end
      end
      2'b11: begin
        if (addr[1:0] == 2'b00) begin
          shadow[idx] = wdata;
        end
      end
      default: ;
    endcase
  endfunction

  // bit 2 of the type picks sign extension, misaligned reads give zero
  function automatic logic [31:0] ref_read(input logic [31:0] addr, input logic [2:0] rtype);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = shadow[addr[9:2]];
    b    = word[8*addr[1:0] +: 8];
    h    = word[16*addr[1] +: 16];
    case (rtype[1:0])
      2'b01: return rtype[2] ? {{24{b[7]}}, b} : {24'h0, b};
      2'b10: begin
        if (addr[0]) begin
          return 32'h0;
        end
        return rtype[2] ? {{16{h[15]}}, h} : {16'h0, h};
      end
      2'b11: return (addr[1:0] == 2'b00) ? word : 32'h0;
      default: return 32'h0;
    endcase
  endfunction

  // ------------------------------
  // bus tasks
  // ------------------------------
  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      $display("Error: %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic bus_idle();
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = 2'b00;
    address    = 32'h0;
    data_in    = 32'h0;
  endtask

  task automatic idle_cycle();
    bus_idle();
    @(negedge clk);
  endtask

  // starts right after a falling edge, returns on the falling edge after completion
  task automatic do_access(input logic [31:0] addr, input logic [2:0] rtype,
                           input logic [1:0] wtype, input logic [31:0] wdata);
    int cycles;
    enable     = 1'b1;
    read_type  = rtype;
    write_type = wtype;
    address    = addr;
    data_in    = wdata;
    #1;
    first_ready = data_out_ready;
    first_busy  = busy;
    cycles      = 0;
    while (data_out_ready !== 1'b1 && cycles < ready_timeout) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (data_out_ready !== 1'b1) begin
      $display("timeout: data_out_ready stayed low for address %h", addr);
      errors++;
    end else begin
      check_value(32'(busy), 32'h0, "busy high together with data_out_ready");
    end
    last_rdata = data_out;
    @(negedge clk);
    bus_idle();
  endtask

  task automatic ram_write(input logic [31:0] addr, input logic [1:0] wtype,
                           input logic [31:0] wdata);
    do_access(addr, 3'b000, wtype, wdata);
    ref_write(addr, wtype, wdata);
  endtask

  task automatic ram_read_check(input logic [31:0] addr, input logic [2:0] rtype);
    do_access(addr, rtype, 2'b00, 32'h0);
    check_value(last_rdata, ref_read(addr, rtype), "ram read");
  endtask

  task automatic start_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] val;
    logic [1:0]  wtype;
    int          cycles;
    logic        done;
    clk       = 1'b0;
    rst_n     = 1'b0;
    rng_state = 32'd3;
    checks    = 0;
    errors    = 0;
    bus_idle();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    start_test();
    check_value(32'(led), 32'hf, "led after reset");
    // serial line idles high
    check_value(32'(uart_tx_line), 32'h1, "uart_tx after reset");
    do_access(ramio_pkg::addr_uart_out, 3'b011, 2'b00, 32'h0);
    check_value(last_rdata, 32'hffff_ffff, "uart_out after reset");
    do_access(ramio_pkg::addr_uart_in, 3'b011, 2'b00, 32'h0);
    check_value(last_rdata, 32'hffff_ffff, "uart_in after reset");
    end_test("reset values");

    // known contents everywhere before mixing lanes
    for (int i = 0; i < 256; i++) begin
      ram_write(32'(i) << 2, 2'b11, next_rand());
    end

    start_test();
    // upper address bits are random too, only bits 9..2 pick the word
    for (int i = 0; i < 40; i++) begin
      word_addrs[i] = next_rand() & 32'h0fff_fffc;
      ram_write(word_addrs[i], 2'b11, next_rand());
    end
    for (int i = 0; i < 40; i++) begin
      ram_read_check(word_addrs[i], 3'b011);
    end
    end_test("word write and read");

    start_test();
    for (int i = 0; i < 30; i++) begin
      addr  = next_rand() & 32'h0fff_ffff;
      wtype = (next_rand() % 2 == 0) ? 2'b01 : 2'b10;
      ram_write(addr, wtype, next_rand());
      for (int off = 0; off < 4; off++) begin
        for (int rt = 1; rt < 8; rt++) begin
          if (rt % 4 != 0) begin
            ram_read_check({addr[31:2], 2'(off)}, 3'(rt));
            if (rt % 4 == 2 && off % 2 == 1) begin
              check_value(last_rdata, 32'h0, "misaligned half read");
            end
          end
        end
      end
    end
    end_test("byte and half lanes");

    start_test();
    for (int i = 0; i < 8; i++) begin
      val = next_rand();
      do_access(ramio_pkg::addr_led, 3'b000, 2'b11, val);
      check_value(32'(led), 32'(val[3:0]), "led value");
    end
    // led address aliases word 255, which must be untouched
    ram_read_check(32'h0000_03fc, 3'b011);
    end_test("leds");

    start_test();
    for (int i = 0; i < 8; i++) begin
      val = next_rand();
      do_access(ramio_pkg::addr_uart_out, 3'b000, 2'b01, val);
      do_access(ramio_pkg::addr_uart_out, 3'b011, 2'b00, 32'h0);
      check_value(last_rdata, {24'h0, val[7:0]}, "uart_out right after write");
      // poll until the frame is out
      done   = 1'b0;
      cycles = 0;
      while (!done && cycles < uart_timeout) begin
        do_access(ramio_pkg::addr_uart_out, 3'b011, 2'b00, 32'h0);
        if (last_rdata === 32'hffff_ffff) begin
          done = 1'b1;
        end else begin
          check_value(last_rdata, {24'h0, val[7:0]}, "uart_out while sending");
        end
        cycles++;
      end
      if (!done) begin
        $display("timeout: uart transmit register never went back to idle");
        errors++;
      end
      // idle gaps between polls let the receive capture land
      done   = 1'b0;
      cycles = 0;
      while (!done && cycles < uart_timeout) begin
        do_access(ramio_pkg::addr_uart_in, 3'b011, 2'b00, 32'h0);
        if (last_rdata !== 32'hffff_ffff) begin
          done = 1'b1;
          check_value(last_rdata, {24'h0, val[7:0]}, "uart_in looped byte");
        end else begin
          idle_cycle();
        end
        cycles++;
      end
      if (!done) begin
        $display("timeout: looped back byte never showed up in uart_in");
        errors++;
      end
      do_access(ramio_pkg::addr_uart_in, 3'b011, 2'b00, 32'h0);
      check_value(last_rdata, 32'hffff_ffff, "uart_in after read");
    end
    end_test("uart round trip");

    start_test();
    for (int i = 0; i < 3; i++) begin
      addr = (i == 0) ? ramio_pkg::addr_led :
             (i == 1) ? ramio_pkg::addr_uart_out : ramio_pkg::addr_uart_in;
      do_access(addr, 3'b011, 2'b00, 32'h0);
      check_value(32'(first_ready), 32'h1, "io read ready in first cycle");
      check_value(32'(first_busy), 32'h0, "io read busy in first cycle");
      do_access(addr, 3'b000, 2'b11, 32'hffff_ff00);
      check_value(32'(first_ready), 32'h1, "io write ready in first cycle");
      check_value(32'(first_busy), 32'h0, "io write busy in first cycle");
      // answers even with enable low
      address   = addr;
      read_type = 3'b011;
      #1;
      check_value(32'(data_out_ready), 32'h1, "io ready with enable low");
      check_value(32'(busy), 32'h0, "io busy with enable low");
      @(negedge clk);
      bus_idle();
    end
    // previous access was i/o, so this word is new to the ram
    addr = next_rand() & 32'h0fff_fffc;
    ram_read_check(addr, 3'b011);
    check_value(32'(first_ready), 32'h0, "new ram word ready in first cycle");
    check_value(32'(first_busy), 32'h1, "new ram word busy in first cycle");
    ram_read_check(addr ^ 32'h4, 3'b011);
    check_value(32'(first_ready), 32'h0, "next ram word ready in first cycle");
    end_test("io ready");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/ramio_pkg.sv
hw/ramio.sv
hw/lane_align.sv
hw/word_ram.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ramio_top.sv
tests/ramio_tb.sv
